/* hdl/upd_consts.svh */
////////////////////////////////////////
// Peripheral constants
// Bus and counter widths, register map,
// reset values, vectors and dividers
////////////////////////////////////////

`ifndef UPD_CONSTS_SVH
`define UPD_CONSTS_SVH

// Widths
`define UPD_ADDR_W      8
`define UPD_DATA_W      32
`define UPD_TM_W        12

// Dividers and source count
`define UPD_TM_PRESCALE 8
`define UPD_INT_DIV     12
`define UPD_NUM_INT     4

// Register map, one 32-bit word each
`define UPD_REG_PA      8'h00
`define UPD_REG_PB      8'h04
`define UPD_REG_PC      8'h08
`define UPD_REG_MB      8'h0C
`define UPD_REG_MC      8'h10
`define UPD_REG_MK      8'h14
`define UPD_REG_TM      8'h18
`define UPD_REG_TMSTART 8'h1C
`define UPD_REG_IE      8'h20
`define UPD_REG_IRQ     8'h24
`define UPD_REG_VEC     8'h28

// Mode and mask registers come up all ones
`define UPD_RST_MODE    8'hFF

// Interrupt vectors
`define UPD_VEC_INT0    8'h04
`define UPD_VEC_INTT    8'h08
`define UPD_VEC_INT1    8'h10
`define UPD_VEC_INT2    8'h20
`define UPD_VEC_NONE    8'h00

// AXI responses
`define UPD_RESP_OKAY   2'd0
`define UPD_RESP_SLVERR 2'd2

`endif

/* hdl/upd_pkg.sv */
////////////////////////////////////////
// Shared types of the peripheral block
// AXI4-Lite bus structs, register file
// view and interrupt path structs
////////////////////////////////////////

`include "upd_consts.svh"

package upd_pkg;

  // Source index, 0 wins arbitration
  typedef enum logic [1:0] {
    IDX_INT0 = 2'd0,
    IDX_INTT = 2'd1,
    IDX_INT1 = 2'd2,
    IDX_INT2 = 2'd3
  } int_idx_e;

  // Master side of the bus
  typedef struct packed {
    logic                   awvalid;
    logic [`UPD_ADDR_W-1:0] awaddr;
    logic                   wvalid;
    logic [`UPD_DATA_W-1:0] wdata;
    logic                   bready;
    logic                   arvalid;
    logic [`UPD_ADDR_W-1:0] araddr;
    logic                   rready;
  } axil_req_t;

  // Slave side of the bus
  typedef struct packed {
    logic                   awready;
    logic                   wready;
    logic                   bvalid;
    logic [1:0]             bresp;
    logic                   arready;
    logic                   rvalid;
    logic [`UPD_DATA_W-1:0] rdata;
    logic [1:0]             rresp;
  } axil_rsp_t;

  // Register file contents seen by the other blocks
  typedef struct packed {
    logic [7:0]           pao;
    logic [7:0]           pbo;
    logic [7:0]           pco;
    logic [7:0]           mb;
    logic [7:0]           mc;
    logic [7:0]           mk;
    logic [`UPD_TM_W-1:0] tm_reload;
    logic                 ie;
  } spr_cfg_t;

  // Sampler to pending latch
  typedef struct packed {
    logic [`UPD_NUM_INT-1:0] set;
    logic [`UPD_NUM_INT-1:0] clr;
  } int_evt_t;

  // Host side clear and acknowledge
  typedef struct packed {
    logic [`UPD_NUM_INT-1:0] clr_mask;
    logic                    clr;
    logic                    ack;
  } int_ctl_t;

  // Status returned for register reads
  typedef struct packed {
    logic [`UPD_NUM_INT-1:0] pending;
    logic [7:0]              vector;
  } int_stat_t;

endpackage

/* hdl/port_io.sv */
////////////////////////////////////////
// Ports A, B and C
// Direction from MB and MC, readback
////////////////////////////////////////

`timescale 1ns/1ps

module port_io import upd_pkg::*; (
  input  spr_cfg_t   cfg,
  input  logic [7:0] PB_I,
  input  logic [7:0] PC_I,
  output logic [7:0] PA_O,
  output logic [7:0] PB_O,
  output logic [7:0] PB_OE,
  output logic [7:0] PC_O,
  output logic [7:0] PC_OE,
  output logic [7:0] pb_in,
  output logic [7:0] pc_in
);

  // Mode bit 1 means input
  assign PB_OE = ~cfg.mb;
  // Only PC7 and PC1..0 follow MC, PC6..3 always drive, PC2 never does
  assign PC_OE = {~cfg.mc[7], 4'b1111, 1'b0, ~cfg.mc[1:0]};

  assign PA_O = cfg.pao;
  assign PB_O = cfg.pbo;
  assign PC_O = cfg.pco;

  // Outputs read back the latch, inputs the pin
  assign pb_in = (PB_I & ~PB_OE) | (cfg.pbo & PB_OE);
  assign pc_in = (PC_I & ~PC_OE) | (cfg.pco & PC_OE);

endmodule

/* hdl/tm_timer.sv */
////////////////////////////////////////
// Interval timer
// Prescaler, 12-bit down counter,
// reload and underflow event
////////////////////////////////////////

`timescale 1ns/1ps

`include "upd_consts.svh"

module tm_timer (
  input  logic                 CLK,
  input  logic                 rst,
  input  logic [`UPD_TM_W-1:0] tm_reload,
  input  logic                 tm_start,
  output logic                 tm_uf
);

  localparam int PS_W = $clog2(`UPD_TM_PRESCALE);
  localparam int TC_W = `UPD_TM_W + PS_W;

  // Counter on top, prescaler in the low bits
  logic [TC_W-1:0] tc;
  logic [TC_W-1:0] tc_load;

  assign tc_load = {tm_reload, PS_W'(`UPD_TM_PRESCALE - 1)};

  // Fires the cycle the whole chain reaches zero
  assign tm_uf = (tc == '0);

  always_ff @(posedge CLK) begin
    if (rst) begin
      tc <= '1;
    end else if (tm_uf || tm_start) begin
      // Reload restarts the prescaler as well
      tc <= tc_load;
    end else begin
      tc <= tc - 1'b1;
    end
  end

endmodule

/* hdl/int_sampler.sv */
////////////////////////////////////////
// Interrupt sampling
// Divide-by-12 tick, INT1/INT2 edge
// filters, INT0 level, timer event
////////////////////////////////////////

`timescale 1ns/1ps

`include "upd_consts.svh"

module int_sampler import upd_pkg::*; (
  input  logic     CLK,
  input  logic     rst,
  input  logic     INT0,
  input  logic     INT1,
  input  logic     INT2,
  input  logic     int2_rising,
  input  logic     tm_uf,
  input  logic     int0_pending,
  output int_evt_t evt
);

  logic [3:0] div_cnt;
  logic       tick;
  logic [3:0] hist1;
  logic [3:0] hist2;
  int_evt_t   evt_d;

  assign tick = (div_cnt == 4'(`UPD_INT_DIV - 1));

  always_ff @(posedge CLK) begin
    if (rst) begin
      div_cnt <= '0;
      // All ones so an idle high pin does not look like an edge
      hist1   <= 4'b1111;
      hist2   <= 4'b1111;
    end else begin
      div_cnt <= tick ? 4'd0 : div_cnt + 1'b1;
      if (tick) begin
        hist1 <= {hist1[2:0], INT1};
        // Inverted when falling edges are selected
        hist2 <= {hist2[2:0], INT2 ^ ~int2_rising};
      end
    end
  end

  always_comb begin
    evt_d = '0;
    // INT0 tracks the pin level
    evt_d.set[IDX_INT0] = INT0 & ~int0_pending;
    evt_d.clr[IDX_INT0] = ~INT0 & int0_pending;
    evt_d.set[IDX_INTT] = tm_uf;
    // One low sample then three high
    evt_d.set[IDX_INT1] = tick & (hist1 == 4'b0111);
    evt_d.set[IDX_INT2] = tick & (hist2 == 4'b0111);
  end

  always_ff @(posedge CLK) begin
    if (rst)
      evt <= '0;
    else
      evt <= evt_d;
  end

endmodule

/* hdl/int_arbiter.sv */
////////////////////////////////////////
// Interrupt controller
// Pending latch, masking, priority,
// vector and request output
////////////////////////////////////////

`timescale 1ns/1ps

`include "upd_consts.svh"

module int_arbiter import upd_pkg::*; (
  input  logic      CLK,
  input  logic      rst,
  input  int_evt_t  evt,
  input  spr_cfg_t  cfg,
  input  int_ctl_t  ictl,
  output int_stat_t stat,
  output logic      int0_pending,
  output logic      irq
);

  logic [`UPD_NUM_INT-1:0] pending;
  logic [`UPD_NUM_INT-1:0] enabled;
  logic [`UPD_NUM_INT-1:0] grant;
  logic [`UPD_NUM_INT-1:0] clr_all;
  int_idx_e                sel;

  // MK bits 3..0 line up with the source index
  assign enabled = pending & ~cfg.mk[`UPD_NUM_INT-1:0] & {`UPD_NUM_INT{cfg.ie}};

  ////////////////////////////////////////
  // Priority encoder

  always_comb begin
    grant = '0;
    sel   = IDX_INT0;
    // Walk down so the lowest index is left
    for (int i = `UPD_NUM_INT - 1; i >= 0; i--) begin
      if (enabled[i]) begin
        grant    = '0;
        grant[i] = 1'b1;
        sel      = int_idx_e'(i);
      end
    end
  end

  always_comb begin
    if (enabled == '0) begin
      stat.vector = `UPD_VEC_NONE;
    end else begin
      case (sel)
        IDX_INT0: stat.vector = `UPD_VEC_INT0;
        IDX_INTT: stat.vector = `UPD_VEC_INTT;
        IDX_INT1: stat.vector = `UPD_VEC_INT1;
        default:  stat.vector = `UPD_VEC_INT2;
      endcase
    end
  end

  ////////////////////////////////////////
  // Pending latch

  // Host clear and acknowledge merged with the sampler clears
  assign clr_all = evt.clr | ({`UPD_NUM_INT{ictl.clr}} & ictl.clr_mask) |
                   ({`UPD_NUM_INT{ictl.ack}} & grant);

  always_ff @(posedge CLK) begin
    if (rst) begin
      pending <= '0;
      irq     <= 1'b0;
    end else begin
      pending <= (pending & ~clr_all) | evt.set;
      irq     <= |enabled;
    end
  end

  assign stat.pending = pending;
  assign int0_pending = pending[IDX_INT0];

endmodule

/* hdl/spr_axil.sv */
////////////////////////////////////////
// AXI4-Lite slave for the special
// registers: handshakes, register file,
// read mux and strobes to timer and IRQ
////////////////////////////////////////

`timescale 1ns/1ps

`include "upd_consts.svh"

module spr_axil import upd_pkg::*; (
  input  logic       CLK,
  input  logic       rst,
  input  axil_req_t  axi_req,
  output axil_rsp_t  axi_rsp,
  output spr_cfg_t   cfg,
  input  logic [7:0] pb_in,
  input  logic [7:0] pc_in,
  input  int_stat_t  stat,
  output logic       tm_start,
  output int_ctl_t   ictl
);

  spr_cfg_t               cfg_q;
  logic                   wr_hs;
  logic                   rd_hs;
  logic                   wr_ok;
  logic                   rd_ok;
  logic [`UPD_DATA_W-1:0] rd_word;
  logic                   bvalid_q;
  logic [1:0]             bresp_q;
  logic                   rvalid_q;
  logic [1:0]             rresp_q;
  logic [`UPD_DATA_W-1:0] rdata_q;

  ////////////////////////////////////////
  // Handshakes

  // Address and data taken together, blocked by a held response
  assign wr_hs = axi_req.awvalid & axi_req.wvalid & ~bvalid_q;
  assign rd_hs = axi_req.arvalid & ~rvalid_q;

  always_comb begin
    case (axi_req.awaddr)
      `UPD_REG_PA, `UPD_REG_PB, `UPD_REG_PC, `UPD_REG_MB,
      `UPD_REG_MC, `UPD_REG_MK, `UPD_REG_TM, `UPD_REG_TMSTART,
      `UPD_REG_IE, `UPD_REG_IRQ, `UPD_REG_VEC: wr_ok = 1'b1;
      default: wr_ok = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // Register file

  always_ff @(posedge CLK) begin
    if (rst) begin
      cfg_q <= '{pao: 8'h00, pbo: 8'h00, pco: 8'h00,
                 mb: `UPD_RST_MODE, mc: `UPD_RST_MODE, mk: `UPD_RST_MODE,
                 tm_reload: {`UPD_TM_W{1'b1}}, ie: 1'b0};
    end else if (wr_hs) begin
      case (axi_req.awaddr)
        `UPD_REG_PA: cfg_q.pao <= axi_req.wdata[7:0];
        `UPD_REG_PB: cfg_q.pbo <= axi_req.wdata[7:0];
        `UPD_REG_PC: cfg_q.pco <= axi_req.wdata[7:0];
        `UPD_REG_MB: cfg_q.mb <= axi_req.wdata[7:0];
        `UPD_REG_MC: cfg_q.mc <= axi_req.wdata[7:0];
        `UPD_REG_MK: cfg_q.mk <= axi_req.wdata[7:0];
        `UPD_REG_TM: cfg_q.tm_reload <= axi_req.wdata[`UPD_TM_W-1:0];
        `UPD_REG_IE: cfg_q.ie <= axi_req.wdata[0];
        default: ;
      endcase
    end
  end

  assign cfg = cfg_q;

  // Timer start and pending clear act on the write handshake
  assign tm_start      = wr_hs & (axi_req.awaddr == `UPD_REG_TMSTART);
  assign ictl.clr      = wr_hs & (axi_req.awaddr == `UPD_REG_IRQ);
  assign ictl.clr_mask = axi_req.wdata[`UPD_NUM_INT-1:0];
  // Reading the vector acknowledges it
  assign ictl.ack      = rd_hs & (axi_req.araddr == `UPD_REG_VEC);

  ////////////////////////////////////////
  // Read mux

  always_comb begin
    rd_word = '0;
    rd_ok   = 1'b1;
    case (axi_req.araddr)
      `UPD_REG_PA:      rd_word[7:0] = cfg_q.pao;
      `UPD_REG_PB:      rd_word[7:0] = pb_in;
      `UPD_REG_PC:      rd_word[7:0] = pc_in;
      `UPD_REG_MB:      rd_word[7:0] = cfg_q.mb;
      `UPD_REG_MC:      rd_word[7:0] = cfg_q.mc;
      `UPD_REG_MK:      rd_word[7:0] = cfg_q.mk;
      `UPD_REG_TM:      rd_word[`UPD_TM_W-1:0] = cfg_q.tm_reload;
      `UPD_REG_TMSTART: rd_word = '0;
      `UPD_REG_IE:      rd_word[0] = cfg_q.ie;
      `UPD_REG_IRQ:     rd_word[`UPD_NUM_INT-1:0] = stat.pending;
      `UPD_REG_VEC:     rd_word[7:0] = stat.vector;
      default:          rd_ok = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // Response channels

  always_ff @(posedge CLK) begin
    if (rst) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_hs)
        bvalid_q <= 1'b1;
      else if (axi_req.bready)
        bvalid_q <= 1'b0;
      if (rd_hs)
        rvalid_q <= 1'b1;
      else if (axi_req.rready)
        rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (wr_hs)
      bresp_q <= wr_ok ? `UPD_RESP_OKAY : `UPD_RESP_SLVERR;
    if (rd_hs) begin
      rdata_q <= rd_word;
      rresp_q <= rd_ok ? `UPD_RESP_OKAY : `UPD_RESP_SLVERR;
    end
  end

  assign axi_rsp.awready = wr_hs;
  assign axi_rsp.wready  = wr_hs;
  assign axi_rsp.bvalid  = bvalid_q;
  assign axi_rsp.bresp   = bresp_q;
  assign axi_rsp.arready = rd_hs;
  assign axi_rsp.rvalid  = rvalid_q;
  assign axi_rsp.rdata   = rdata_q;
  assign axi_rsp.rresp   = rresp_q;

endmodule

/* hdl/upd_periph.sv */
////////////////////////////////////////
// Peripheral block top level
// Register slave, ports, timer and
// interrupt controller tied together
////////////////////////////////////////

`timescale 1ns/1ps

module upd_periph import upd_pkg::*; (
  input  logic       CLK,
  input  logic       rst,
  input  axil_req_t  axi_req,
  output axil_rsp_t  axi_rsp,
  output logic [7:0] PA_O,
  input  logic [7:0] PB_I,
  output logic [7:0] PB_O,
  output logic [7:0] PB_OE,
  input  logic [7:0] PC_I,
  output logic [7:0] PC_O,
  output logic [7:0] PC_OE,
  input  logic       INT0,
  input  logic       INT1,
  input  logic       INT2,
  output logic       irq
);

  spr_cfg_t   cfg;
  int_stat_t  stat;
  int_ctl_t   ictl;
  int_evt_t   evt;
  logic [7:0] pb_in;
  logic [7:0] pc_in;
  logic       tm_start;
  logic       tm_uf;
  logic       int0_pending;

  spr_axil spr0 (
    .CLK      (CLK),
    .rst      (rst),
    .axi_req  (axi_req),
    .axi_rsp  (axi_rsp),
    .cfg      (cfg),
    .pb_in    (pb_in),
    .pc_in    (pc_in),
    .stat     (stat),
    .tm_start (tm_start),
    .ictl     (ictl)
  );

  port_io port0 (
    .cfg   (cfg),
    .PB_I  (PB_I),
    .PC_I  (PC_I),
    .PA_O  (PA_O),
    .PB_O  (PB_O),
    .PB_OE (PB_OE),
    .PC_O  (PC_O),
    .PC_OE (PC_OE),
    .pb_in (pb_in),
    .pc_in (pc_in)
  );

  tm_timer tm0 (
    .CLK       (CLK),
    .rst       (rst),
    .tm_reload (cfg.tm_reload),
    .tm_start  (tm_start),
    .tm_uf     (tm_uf)
  );

  // MK bit 5 selects the INT2 edge
  int_sampler smp0 (
    .CLK          (CLK),
    .rst          (rst),
    .INT0         (INT0),
    .INT1         (INT1),
    .INT2         (INT2),
    .int2_rising  (cfg.mk[5]),
    .tm_uf        (tm_uf),
    .int0_pending (int0_pending),
    .evt          (evt)
  );

  int_arbiter arb0 (
    .CLK          (CLK),
    .rst          (rst),
    .evt          (evt),
    .cfg          (cfg),
    .ictl         (ictl),
    .stat         (stat),
    .int0_pending (int0_pending),
    .irq          (irq)
  );

endmodule

/* dv/tb_upd_periph.sv */
////////////////////////////////////////
// Testbench for the peripheral block
// AXI4-Lite tasks, directed tests of
// ports, timer and interrupts, watchdog
////////////////////////////////////////

`timescale 1ns/1ps

`include "upd_consts.svh"

module tb_upd_periph import upd_pkg::*; ();

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 8;
  // Per-test cycle budgets summed for the watchdog
  localparam int BUDGET_TOTAL = 40 + 100 + 250 + 300 + 150 + 350;

  logic       CLK = 1'b0;
  logic       rst;
  axil_req_t  axi_req;
  axil_rsp_t  axi_rsp;
  logic [7:0] pa_o;
  logic [7:0] pb_i;
  logic [7:0] pb_o;
  logic [7:0] pb_oe;
  logic [7:0] pc_i;
  logic [7:0] pc_o;
  logic [7:0] pc_oe;
  logic       int0;
  logic       int1;
  logic       int2;
  logic       irq;
  int         cyc = 0;
  integer     seed = 43148;

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  always @(posedge CLK) cyc <= cyc + 1;

  upd_periph dut0 (
    .CLK (CLK), .rst (rst), .axi_req (axi_req), .axi_rsp (axi_rsp),
    .PA_O (pa_o), .PB_I (pb_i), .PB_O (pb_o), .PB_OE (pb_oe),
    .PC_I (pc_i), .PC_O (pc_o), .PC_OE (pc_oe),
    .INT0 (int0), .INT1 (int1), .INT2 (int2), .irq (irq)
  );

  ////////////////////////////////////////
  // Reporting and bus helpers

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string test, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected === actual) else
      stop_run($sformatf("FAILED %s expected 0x%0h actual 0x%0h", test, expected, actual));
  endtask

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    @(posedge CLK);
    axi_req.awvalid <= 1'b1;
    axi_req.awaddr  <= addr;
    axi_req.wvalid  <= 1'b1;
    axi_req.wdata   <= data;
    @(negedge CLK);
    while (!axi_rsp.awready) @(negedge CLK);
    @(posedge CLK);
    axi_req.awvalid <= 1'b0;
    axi_req.wvalid  <= 1'b0;
    @(negedge CLK);
    while (!axi_rsp.bvalid) @(negedge CLK);
    resp = axi_rsp.bresp;
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    @(posedge CLK);
    axi_req.arvalid <= 1'b1;
    axi_req.araddr  <= addr;
    @(negedge CLK);
    while (!axi_rsp.arready) @(negedge CLK);
    @(posedge CLK);
    axi_req.arvalid <= 1'b0;
    @(negedge CLK);
    while (!axi_rsp.rvalid) @(negedge CLK);
    data = axi_rsp.rdata;
    resp = axi_rsp.rresp;
  endtask

  // Register access that also expects an OKAY response
  task automatic write_reg(input string test, input logic [7:0] addr, input logic [31:0] data);
    logic [1:0] resp;
    axi_write(addr, data, resp);
    check_value(test, `UPD_RESP_OKAY, resp);
  endtask

  task automatic read_reg(input string test, input logic [7:0] addr, output logic [31:0] data);
    logic [1:0] resp;
    axi_read(addr, data, resp);
    check_value(test, `UPD_RESP_OKAY, resp);
  endtask

  task automatic expect_reg(input string test, input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] data;
    read_reg(test, addr, data);
    check_value(test, exp, data);
  endtask

  // Polls IRQ until the bit is pending or the cycle limit runs out
  task automatic wait_pending(input string test, input int idx, input int max_cycles);
    logic [31:0] data;
    int          start;
    start = cyc;
    data  = '0;
    while (!data[idx] && (cyc - start) <= max_cycles)
      read_reg(test, `UPD_REG_IRQ, data);
    assert (data[idx]) else
      stop_run($sformatf("%s: pending bit %0d not set within %0d cycles",
                         test, idx, max_cycles));
  endtask

  task automatic wait_irq(input string test, input logic level, input int max_cycles);
    int n;
    n = 0;
    @(negedge CLK);
    while (irq !== level && n < max_cycles) begin
      @(negedge CLK);
      n++;
    end
    assert (irq === level) else
      stop_run($sformatf("%s: irq did not reach %0b within %0d cycles",
                         test, level, max_cycles));
  endtask

  ////////////////////////////////////////
  // Directed tests

  task automatic test_reset;
    @(negedge CLK);
    check_value("test_reset", 8'h00, pb_oe);
    check_value("test_reset", 8'h78, pc_oe);
    check_value("test_reset", 1'b0, irq);
    check_value("test_reset", 24'h0, {pa_o, pb_o, pc_o});
    expect_reg("test_reset", `UPD_REG_MK, 32'hFF);
    expect_reg("test_reset", `UPD_REG_MB, 32'hFF);
    expect_reg("test_reset", `UPD_REG_VEC, 32'h00);
  endtask

  task automatic test_ports;
    logic [7:0] val;
    logic [7:0] mode;
    logic [7:0] pin;
    logic [7:0] oe;
    logic [7:0] rb;
    val = 8'($random(seed));
    write_reg("test_ports", `UPD_REG_PA, {24'h0, val});
    check_value("test_ports", val, pa_o);
    // Port B with mode bit 1 as input
    mode = 8'($random(seed));
    val  = 8'($random(seed));
    pin  = 8'($random(seed));
    oe   = ~mode;
    @(posedge CLK);
    pb_i <= pin;
    write_reg("test_ports", `UPD_REG_MB, {24'h0, mode});
    write_reg("test_ports", `UPD_REG_PB, {24'h0, val});
    check_value("test_ports", oe, pb_oe);
    check_value("test_ports", val, pb_o);
    expect_reg("test_ports", `UPD_REG_PB, {24'h0, (pin & mode) | (val & ~mode)});
    // Port C has PC6..3 as fixed outputs and PC2 as a fixed input
    mode = 8'($random(seed));
    val  = 8'($random(seed));
    pin  = 8'($random(seed));
    oe   = (~mode & 8'h83) | 8'h78;
    for (int i = 0; i < 8; i++)
      rb[i] = oe[i] ? val[i] : pin[i];
    @(posedge CLK);
    pc_i <= pin;
    write_reg("test_ports", `UPD_REG_MC, {24'h0, mode});
    write_reg("test_ports", `UPD_REG_PC, {24'h0, val});
    check_value("test_ports", oe, pc_oe);
    check_value("test_ports", val, pc_o);
    expect_reg("test_ports", `UPD_REG_PC, {24'h0, rb});
  endtask

  task automatic test_int1_edge;
    @(posedge CLK);
    int1 <= 1'b0;
    repeat (60) @(posedge CLK);
    int1 <= 1'b1;
    wait_pending("test_int1_edge", 2, 100);
    write_reg("test_int1_edge", `UPD_REG_IE, 32'h1);
    write_reg("test_int1_edge", `UPD_REG_MK, 32'hFB);
    wait_irq("test_int1_edge", 1'b1, 4);
    expect_reg("test_int1_edge", `UPD_REG_VEC, 32'h10);
    expect_reg("test_int1_edge", `UPD_REG_IRQ, 32'h0);
    wait_irq("test_int1_edge", 1'b0, 4);
  endtask

  task automatic test_priority;
    @(posedge CLK);
    int1 <= 1'b0;
    repeat (60) @(posedge CLK);
    int1 <= 1'b1;
    wait_pending("test_priority", 2, 100);
    write_reg("test_priority", `UPD_REG_MK, 32'hFA);
    @(posedge CLK);
    int0 <= 1'b1;
    wait_pending("test_priority", 0, 20);
    // INT0 outranks INT1
    expect_reg("test_priority", `UPD_REG_VEC, 32'h04);
    @(posedge CLK);
    int0 <= 1'b0;
    repeat (6) @(posedge CLK);
    write_reg("test_priority", `UPD_REG_IRQ, 32'h1);
    expect_reg("test_priority", `UPD_REG_VEC, 32'h10);
    expect_reg("test_priority", `UPD_REG_IRQ, 32'h0);
  endtask

  task automatic test_timer_mask;
    write_reg("test_timer_mask", `UPD_REG_TM, 32'h3);
    write_reg("test_timer_mask", `UPD_REG_TMSTART, 32'h0);
    wait_pending("test_timer_mask", 1, 64);
    // Still masked by MK bit 1
    check_value("test_timer_mask", 1'b0, irq);
    // Long reload so no new underflow lands during the clear
    write_reg("test_timer_mask", `UPD_REG_TM, 32'hFFF);
    write_reg("test_timer_mask", `UPD_REG_TMSTART, 32'h0);
    write_reg("test_timer_mask", `UPD_REG_MK, 32'hF8);
    wait_irq("test_timer_mask", 1'b1, 4);
    write_reg("test_timer_mask", `UPD_REG_IRQ, 32'h2);
    expect_reg("test_timer_mask", `UPD_REG_IRQ, 32'h0);
    wait_irq("test_timer_mask", 1'b0, 4);
  endtask

  task automatic test_int2_polarity_and_slverr;
    logic [31:0] data;
    logic [1:0]  resp;
    // MK bit 5 low selects the falling edge
    write_reg("test_int2_polarity_and_slverr", `UPD_REG_MK, 32'hD8);
    // History settles on the inverted idle level
    repeat (60) @(posedge CLK);
    int2 <= 1'b0;
    wait_pending("test_int2_polarity_and_slverr", 3, 100);
    write_reg("test_int2_polarity_and_slverr", `UPD_REG_IRQ, 32'h8);
    repeat (60) @(posedge CLK);
    int2 <= 1'b1;
    repeat (60) @(posedge CLK);
    expect_reg("test_int2_polarity_and_slverr", `UPD_REG_IRQ, 32'h0);
    axi_read(8'h3C, data, resp);
    check_value("test_int2_polarity_and_slverr", `UPD_RESP_SLVERR, resp);
    axi_write(8'h3C, 32'hA5, resp);
    check_value("test_int2_polarity_and_slverr", `UPD_RESP_SLVERR, resp);
  endtask

  ////////////////////////////////////////
  // Sequence and watchdog

  initial begin
    rst     = 1'b1;
    axi_req = '0;
    axi_req.bready = 1'b1;
    axi_req.rready = 1'b1;
    pb_i    = 8'h00;
    pc_i    = 8'h00;
    int0    = 1'b0;
    int1    = 1'b1;
    int2    = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLK);
    rst <= 1'b0;
    test_reset();
    test_ports();
    test_int1_edge();
    test_priority();
    test_timer_mask();
    test_int2_polarity_and_slverr();
    $display("PASS: all tests");
    $finish;
  end

  initial begin
    #(2 * BUDGET_TOTAL * CLK_PERIOD);
    stop_run("Watchdog expired before the tests finished");
  end

endmodule

/* filelist.f */
+incdir+hdl
hdl/upd_pkg.sv
hdl/port_io.sv
hdl/tm_timer.sv
hdl/int_sampler.sv
hdl/int_arbiter.sv
hdl/spr_axil.sv
hdl/upd_periph.sv
dv/tb_upd_periph.sv
